//--- axil_response.sv
`timescale 1ns/10ps

module axil_response import nes_bus_pkg::*; (
    input  logic                      clock,
    input  logic                      reset_n,

    input  bus_rsp_t                  rsp,

    output logic                      bvalid,
    output logic [1:0]                bresp,
    input  logic                      bready,

    output logic                      rvalid,
    output logic [1:0]                rresp,
    output logic [AXIL_DATA_BITS-1:0] rdata,
    input  logic                      rready,

    output logic                      busy
);

    logic b_hold;
    logic r_hold;

    // Valid comes straight from the fresh response, then from the hold flag
    assign bvalid = (rsp.valid && rsp.write) || b_hold;
    assign rvalid = (rsp.valid && !rsp.write) || r_hold;

    // Payload in rsp stays put until the next acceptance
    assign bresp = rsp.resp;
    assign rresp = rsp.resp;
    assign rdata = {{(AXIL_DATA_BITS-$bits(bus_data_t)){1'b0}}, rsp.rdata};

    assign busy = bvalid || rvalid;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            b_hold <= 1'b0;
            r_hold <= 1'b0;
        end else begin
            b_hold <= bvalid && !bready;
            r_hold <= rvalid && !rready;
        end
    end

endmodule : axil_response

//--- axil_slave_port.sv
`timescale 1ns/10ps

module axil_slave_port import nes_bus_pkg::*; (
    input  logic                          clock,
    input  logic                          reset_n,

    input  logic                          awvalid,
    input  bus_addr_t                     awaddr,
    output logic                          awready,

    input  logic                          wvalid,
    input  logic [AXIL_DATA_BITS-1:0]     wdata,
    input  logic [AXIL_DATA_BITS/8-1:0]   wstrb,
    output logic                          wready,

    input  logic                          arvalid,
    input  bus_addr_t                     araddr,
    output logic                          arready,

    input  logic                          busy,
    output bus_req_t                      req
);

    logic wr_go;
    logic rd_go;

    // Write needs both address and data present
    assign wr_go = awvalid && wvalid && !busy;

    // Read only when no write goes this cycle
    assign rd_go = arvalid && !busy && !wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    always_comb begin
        req.valid  = wr_go || rd_go;
        req.write  = wr_go;
        // Reads always count as full-lane accesses
        req.strobe = wr_go ? wstrb[0] : 1'b1;
        req.addr   = wr_go ? awaddr : araddr;
        req.wdata  = wdata[$bits(bus_data_t)-1:0];
    end

endmodule : axil_slave_port

//--- controller_port.sv
`timescale 1ns/10ps

module controller_port import nes_bus_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,

    input  logic      rd_p1,
    input  logic      rd_p2,
    input  logic      latch_wr,
    input  logic      latch_val,

    input  logic      ctlr_data_p1,
    input  logic      ctlr_data_p2,
    output logic      ctlr_pulse_p1,
    output logic      ctlr_pulse_p2,
    output logic      ctlr_latch,

    output bus_data_t button
);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctlr_latch    <= 1'b0;
            ctlr_pulse_p1 <= 1'b1;
            ctlr_pulse_p2 <= 1'b1;
        end else begin
            if (latch_wr) begin
                ctlr_latch <= latch_val;
            end
            // One low cycle per read, the rising edge shifts the pad
            ctlr_pulse_p1 <= !rd_p1;
            ctlr_pulse_p2 <= !rd_p2;
        end
    end

    // Data pins are active low
    always_ff @(posedge clock) begin
        if (rd_p1) begin
            button <= {7'b0, ~ctlr_data_p1};
        end else if (rd_p2) begin
            button <= {7'b0, ~ctlr_data_p2};
        end
    end

endmodule : controller_port

//--- cpu_bus_map.sv
`timescale 1ns/10ps

module cpu_bus_map import nes_bus_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,

    input  bus_req_t  req,
    output bus_rsp_t  rsp,

    output ppu_req_t  ppu_req,
    input  bus_data_t ppu_rdata,

    input  logic      ctlr_data_p1,
    input  logic      ctlr_data_p2,
    output logic      ctlr_pulse_p1,
    output logic      ctlr_pulse_p2,
    output logic      ctlr_latch
);

    logic       is_ram;
    logic       is_ppu;
    logic       is_dma;
    logic       is_ctl1;
    logic       is_ctl2;
    logic       mapped;
    logic       lane_ok;

    logic       ram_en;
    bus_data_t  ram_rdata;
    bus_data_t  button;

    logic       rsp_valid_q;
    logic       write_q;
    axil_resp_t resp_q;
    logic       src_ram_q;
    logic       src_ctl_q;
    bus_data_t  data_q;

    // Range decode
    assign is_ram  = req.addr < RAM_END;
    assign is_ppu  = !is_ram && (req.addr < PPU_END);
    assign is_dma  = req.addr == OAMDMA_ADDR;
    assign is_ctl1 = req.addr == CTLR1_ADDR;
    assign is_ctl2 = req.addr == CTLR2_ADDR;

    // $4017 is read-only here, writes belong to the APU
    assign mapped  = is_ram || is_ppu || is_dma || is_ctl1 || (is_ctl2 && !req.write);

    // A write with lane 0 masked touches nothing
    assign lane_ok = !req.write || req.strobe;

    always_comb begin
        ppu_req.en    = req.valid && (is_ppu || is_dma) && lane_ok;
        ppu_req.write = req.write;
        ppu_req.sel   = is_dma ? OAMDMA : ppu_reg_t'(req.addr[PPU_INDEX_BITS-1:0]);
        ppu_req.wdata = req.wdata;
    end

    assign ram_en = req.valid && is_ram && lane_ok;

    work_ram u_work_ram (
        .clock (clock),
        .en    (ram_en),
        .write (req.write),
        .addr  (req.addr[RAM_ADDR_BITS-1:0]),
        .wdata (req.wdata),
        .rdata (ram_rdata)
    );

    controller_port u_controller_port (
        .clock         (clock),
        .reset_n       (reset_n),
        .rd_p1         (req.valid && !req.write && is_ctl1),
        .rd_p2         (req.valid && !req.write && is_ctl2),
        .latch_wr      (req.valid && req.write && req.strobe && is_ctl1),
        .latch_val     (req.wdata[0]),
        .ctlr_data_p1  (ctlr_data_p1),
        .ctlr_data_p2  (ctlr_data_p2),
        .ctlr_pulse_p1 (ctlr_pulse_p1),
        .ctlr_pulse_p2 (ctlr_pulse_p2),
        .ctlr_latch    (ctlr_latch),
        .button        (button)
    );

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req.valid;
        end
    end

    // Response payload, captured on the acceptance edge
    always_ff @(posedge clock) begin
        if (req.valid) begin
            write_q   <= req.write;
            resp_q    <= mapped ? OKAY : DECERR;
            src_ram_q <= !req.write && is_ram;
            src_ctl_q <= !req.write && (is_ctl1 || is_ctl2);
            data_q    <= (!req.write && (is_ppu || is_dma)) ? ppu_rdata : '0;
        end
    end

    // RAM and button bytes are already registered at their source
    always_comb begin
        rsp.valid = rsp_valid_q;
        rsp.write = write_q;
        rsp.resp  = resp_q;
        if (src_ram_q) begin
            rsp.rdata = ram_rdata;
        end else if (src_ctl_q) begin
            rsp.rdata = button;
        end else begin
            rsp.rdata = data_q;
        end
    end

endmodule : cpu_bus_map

//--- nes_bus_pkg.sv
package nes_bus_pkg;

    // CPU bus address and data
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // PPU register selects, OAMDMA sits past the mirrored eight
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } ppu_reg_t;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axil_resp_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        logic      strobe;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        axil_resp_t resp;
        bus_data_t  rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic      en;
        logic      write;
        ppu_reg_t  sel;
        bus_data_t wdata;
    } ppu_req_t;

    // Address map
    localparam int        RAM_ADDR_BITS  = 11;
    localparam bus_addr_t RAM_END        = 16'h2000;
    localparam bus_addr_t PPU_END        = 16'h4000;
    localparam bus_addr_t OAMDMA_ADDR    = 16'h4014;
    localparam bus_addr_t CTLR1_ADDR     = 16'h4016;
    localparam bus_addr_t CTLR2_ADDR     = 16'h4017;
    localparam int        PPU_INDEX_BITS = 3;
    localparam int        AXIL_DATA_BITS = 32;

endpackage : nes_bus_pkg

//--- nes_cpu_bus_top.f
nes_bus_pkg.sv
work_ram.sv
controller_port.sv
axil_slave_port.sv
cpu_bus_map.sv
axil_response.sv
nes_cpu_bus_top.sv
tb_nes_cpu_bus.sv

//--- nes_cpu_bus_top.sv
`timescale 1ns/10ps

module nes_cpu_bus_top import nes_bus_pkg::*; (
    input  logic                        clock,
    input  logic                        reset_n,

    input  logic                        awvalid,
    output logic                        awready,
    input  bus_addr_t                   awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [AXIL_DATA_BITS-1:0]   wdata,
    input  logic [AXIL_DATA_BITS/8-1:0] wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  bus_addr_t                   araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [AXIL_DATA_BITS-1:0]   rdata,
    output logic [1:0]                  rresp,

    output ppu_req_t                    ppu_req,
    input  bus_data_t                   ppu_rdata,

    input  logic                        ctlr_data_p1,
    input  logic                        ctlr_data_p2,
    output logic                        ctlr_pulse_p1,
    output logic                        ctlr_pulse_p2,
    output logic                        ctlr_latch
);

    bus_req_t req;
    bus_rsp_t rsp;
    logic     busy;

    axil_slave_port u_axil_slave_port (
        .clock   (clock),
        .reset_n (reset_n),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .busy    (busy),
        .req     (req)
    );

    cpu_bus_map u_cpu_bus_map (
        .clock         (clock),
        .reset_n       (reset_n),
        .req           (req),
        .rsp           (rsp),
        .ppu_req       (ppu_req),
        .ppu_rdata     (ppu_rdata),
        .ctlr_data_p1  (ctlr_data_p1),
        .ctlr_data_p2  (ctlr_data_p2),
        .ctlr_pulse_p1 (ctlr_pulse_p1),
        .ctlr_pulse_p2 (ctlr_pulse_p2),
        .ctlr_latch    (ctlr_latch)
    );

    axil_response u_axil_response (
        .clock   (clock),
        .reset_n (reset_n),
        .rsp     (rsp),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .rvalid  (rvalid),
        .rresp   (rresp),
        .rdata   (rdata),
        .rready  (rready),
        .busy    (busy)
    );

endmodule : nes_cpu_bus_top

//--- tb_nes_cpu_bus.sv
`timescale 1ns/10ps

module tb_nes_cpu_bus import nes_bus_pkg::*; ();

    // RAM 18, PPU 18, controllers 18, decode errors 7
    localparam int TXN_TOTAL = 61;

    logic        clock;
    logic        reset_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    bus_addr_t   awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    ppu_req_t    ppu_req;
    bus_data_t   ppu_rdata;
    logic        ctlr_data_p1, ctlr_data_p2;
    logic        ctlr_pulse_p1, ctlr_pulse_p2, ctlr_latch;

    bus_data_t   ppu_regs [0:15];
    ppu_req_t    ppu_last;
    int          ppu_count;
    bus_data_t   buttons1, buttons2, pad1, pad2;
    logic        pulse1_q, pulse2_q;
    int          lows1, lows2;
    integer      seed;
    int          errors;
    int          checks;

    nes_cpu_bus_top u_dut (.*);

    always #4 clock = ~clock;

    // Pad data pins are active low
    assign ppu_rdata    = reset_n ? ppu_regs[ppu_req.sel] : 8'h00;
    assign ctlr_data_p1 = reset_n ? ~pad1[0] : 1'b1;
    assign ctlr_data_p2 = reset_n ? ~pad2[0] : 1'b1;

    // PPU register file, logs every request
    always @(posedge clock) begin
        if (!reset_n) begin
            for (int k = 0; k < 16; k++) begin
                ppu_regs[k] <= 8'h5A ^ 8'(k * 37);
            end
            ppu_count <= 0;
        end else if (ppu_req.en) begin
            ppu_count <= ppu_count + 1;
            ppu_last  <= ppu_req;
            if (ppu_req.write) begin
                ppu_regs[ppu_req.sel] <= ppu_req.wdata;
            end
        end
    end

    // Pad shift registers, reload while latched, shift on pulse release
    always @(posedge clock) begin
        if (!reset_n) begin
            {pad1, pad2} <= '1;
            {pulse1_q, pulse2_q} <= 2'b11;
            lows1 <= 0;
            lows2 <= 0;
        end else begin
            pulse1_q <= ctlr_pulse_p1;
            pulse2_q <= ctlr_pulse_p2;
            lows1    <= lows1 + (ctlr_pulse_p1 ? 0 : 1);
            lows2    <= lows2 + (ctlr_pulse_p2 ? 0 : 1);
            if (ctlr_latch) begin
                pad1 <= buttons1;
                pad2 <= buttons2;
            end else begin
                if (ctlr_pulse_p1 && !pulse1_q) pad1 <= {1'b1, pad1[7:1]};
                if (ctlr_pulse_p2 && !pulse2_q) pad2 <= {1'b1, pad2[7:1]};
            end
        end
    end

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ppu_sel(input string name, input ppu_reg_t got, input ppu_reg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    // Stalls the response a few cycles while every valid is raised
    task automatic release_response(input logic is_write);
        int         stall;
        logic [1:0] resp0;
        bus_data_t  data0;
        stall = {$random(seed)} % 4;
        resp0 = is_write ? bresp : rresp;
        data0 = rdata[7:0];
        repeat (stall) begin
            @(posedge clock);
            {awvalid, wvalid, arvalid} <= 3'b111;
            wstrb <= 4'h0;
            @(negedge clock);
            if (awready || wready || arready) note_failure("A ready rose while a response was held");
            if (!(is_write ? bvalid : rvalid) || (is_write ? bresp : rresp) !== resp0) begin
                note_failure("Held response changed before it was taken");
            end
            if (!is_write) check_data("rdata", rdata[7:0], data0);
        end
        @(posedge clock);
        {awvalid, wvalid, arvalid} <= 3'b000;
        bready <= is_write;
        rready <= !is_write;
        @(negedge clock);
        if (!(is_write ? bvalid : rvalid)) note_failure("Response dropped before it was taken");
        @(posedge clock);
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic axil_write(input bus_addr_t addr, input bus_data_t data, input logic lane0,
                              output axil_resp_t resp);
        @(posedge clock);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        // Upper lanes carry junk that must be ignored
        wdata   <= {24'hA5C3E1, data};
        wstrb   <= lane0 ? 4'hF : 4'hE;
        @(negedge clock);
        while (!(awready && wready)) @(negedge clock);
        @(posedge clock);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clock);
        if (!bvalid) note_failure("bvalid did not rise one cycle after the write handshake");
        while (!bvalid) @(negedge clock);
        resp = axil_resp_t'(bresp);
        release_response(1'b1);
    endtask

    task automatic axil_read(input bus_addr_t addr, output bus_data_t data,
                             output axil_resp_t resp);
        @(posedge clock);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge clock);
        while (!arready) @(negedge clock);
        @(posedge clock);
        arvalid <= 1'b0;
        @(negedge clock);
        if (!rvalid) note_failure("rvalid did not rise one cycle after the read handshake");
        while (!rvalid) @(negedge clock);
        if (rdata[31:8] !== 24'h0) begin
            errors++;
            $display("[ERROR] rdata[31:8] got 0x%h, expected 0x000000", rdata[31:8]);
        end
        data = rdata[7:0];
        resp = axil_resp_t'(rresp);
        release_response(1'b0);
    endtask

    task automatic reset_test();
        logic [8:0] got;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        got = {awready, wready, arready, bvalid, rvalid, ppu_req.en, ctlr_latch,
               ctlr_pulse_p1, ctlr_pulse_p2};
        checks++;
        if (got !== 9'h003) begin
            errors++;
            $display("[ERROR] control outputs after reset got 0x%h, expected 0x003", got);
        end
    endtask

    task automatic ram_test();
        bus_addr_t  base [8];
        bus_data_t  value [8];
        bus_data_t  got;
        axil_resp_t resp;
        for (int i = 0; i < 8; i++) begin
            base[i]  = 16'(i * 256 + {$random(seed)} % 256);
            value[i] = 8'($random(seed));
            axil_write(base[i] + 16'(({$random(seed)} % 4) * 16'h800), value[i], 1'b1, resp);
            check_resp("bresp", resp, OKAY);
        end
        for (int i = 0; i < 8; i++) begin
            axil_read(base[i] + 16'(({$random(seed)} % 4) * 16'h800), got, resp);
            check_resp("rresp", resp, OKAY);
            check_data("ram rdata", got, value[i]);
        end
        // Lane 0 masked, the byte must survive
        axil_write(base[0] + 16'h1000, ~value[0], 1'b0, resp);
        check_resp("bresp", resp, OKAY);
        axil_read(base[0], got, resp);
        check_data("ram rdata", got, value[0]);
    endtask

    task automatic ppu_test();
        bus_addr_t  addr;
        bus_data_t  value;
        bus_data_t  got;
        ppu_reg_t   sel;
        axil_resp_t resp;
        int         count0;
        for (int i = 0; i <= 8; i++) begin
            addr   = (i == 8) ? OAMDMA_ADDR : (16'h2000 | (16'($random(seed)) & 16'h1FF8));
            addr   = addr | 16'(i % 8);
            sel    = (addr == OAMDMA_ADDR) ? OAMDMA : ppu_reg_t'(4'(addr % 8));
            value  = 8'($random(seed));
            count0 = ppu_count;
            axil_write(addr, value, 1'b1, resp);
            check_resp("bresp", resp, OKAY);
            check_ppu_sel("ppu_req.sel", ppu_last.sel, sel);
            check_data("ppu_req.wdata", ppu_last.wdata, value);
            if (!ppu_last.write || ppu_count != count0 + 1) begin
                note_failure("PPU write request missing or in the wrong direction");
            end
            // Read back through another mirror
            addr = (i == 8) ? addr : (addr ^ 16'h0408);
            axil_read(addr, got, resp);
            check_resp("rresp", resp, OKAY);
            check_ppu_sel("ppu_req.sel", ppu_last.sel, sel);
            check_data("ppu rdata", got, value);
            if (ppu_last.write || ppu_count != count0 + 2) begin
                note_failure("PPU read request missing or in the wrong direction");
            end
        end
    endtask

    task automatic controller_test();
        bus_data_t  got;
        axil_resp_t resp;
        int         lows1_0;
        int         lows2_0;
        buttons1 = 8'($random(seed));
        buttons2 = 8'($random(seed));
        axil_write(CTLR1_ADDR, 8'h01, 1'b1, resp);
        check_data("ctlr_latch", bus_data_t'(ctlr_latch), 8'h01);
        axil_write(CTLR1_ADDR, 8'h00, 1'b1, resp);
        check_data("ctlr_latch", bus_data_t'(ctlr_latch), 8'h00);
        for (int i = 0; i < 16; i++) begin
            lows1_0 = lows1;
            lows2_0 = lows2;
            axil_read((i < 8) ? CTLR1_ADDR : CTLR2_ADDR, got, resp);
            check_resp("rresp", resp, OKAY);
            check_data("pad rdata", got, {7'b0, (i < 8) ? buttons1[i % 8] : buttons2[i % 8]});
            if (lows1 - lows1_0 != ((i < 8) ? 1 : 0) || lows2 - lows2_0 != ((i < 8) ? 0 : 1)) begin
                note_failure("Pad read did not give exactly one clock pulse on its own port");
            end
        end
    endtask

    task automatic decode_test();
        bus_addr_t  bad [4];
        bus_data_t  got;
        axil_resp_t resp;
        int         count0;
        bad    = '{16'h4000, 16'h4018, 16'h8000, CTLR2_ADDR};
        count0 = ppu_count;
        for (int i = 0; i < 4; i++) begin
            if (i < 3) begin
                axil_read(bad[i], got, resp);
                check_resp("rresp", resp, DECERR);
                check_data("rdata", got, 8'h00);
            end
            axil_write(bad[i], 8'hFF, 1'b1, resp);
            check_resp("bresp", resp, DECERR);
        end
        check_data("ctlr_latch", bus_data_t'(ctlr_latch), 8'h00);
        if (ppu_count != count0) note_failure("Unmapped access reached the PPU port");
    endtask

    initial begin
        seed    = 44345;
        errors  = 0;
        checks  = 0;
        clock   = 1'b0;
        reset_n = 1'b0;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        {buttons1, buttons2} = '0;
        reset_test();
        ram_test();
        ppu_test();
        controller_test();
        decode_test();
        @(posedge clock);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // 30 cycles per transaction plus reset
    initial begin
        repeat (TXN_TOTAL * 30 + 4) @(posedge clock);
        $display("Watchdog expired, a handshake never completed");
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Result: FAILED");
        $finish;
    end

endmodule : tb_nes_cpu_bus

//--- work_ram.sv
`timescale 1ns/10ps

module work_ram import nes_bus_pkg::*; (
    input  logic                     clock,
    input  logic                     en,
    input  logic                     write,
    input  logic [RAM_ADDR_BITS-1:0] addr,
    input  bus_data_t                wdata,
    output bus_data_t                rdata
);

    // Only the low address bits reach here, so the 2 KB repeats
    bus_data_t mem [0:(1 << RAM_ADDR_BITS)-1];

    always_ff @(posedge clock) begin
        if (en) begin
            if (write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule : work_ram
